//--- Makefile
# Verilator build and run of the LCD controller testbench
TOP := tb_lcd_ctrl

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- src.f
verilog/lcd_pkg.sv
verilog/lcd_delay_timer.sv
verilog/lcd_bus_cycle.sv
verilog/lcd_sequencer.sv
verilog/lcd_ctrl_top.sv
test/lcd_bus_monitor.sv
test/tb_lcd_ctrl.sv

//--- test/lcd_bus_monitor.sv
// ----------------------------------------------------------------------
// Testbench bus monitor, byte capture on E falling and E timing checks
// ----------------------------------------------------------------------
module lcd_bus_monitor (
	input  logic       CLK,
	input  logic       RST,
	input  logic       lcd_e,
	input  logic       lcd_rs,
	input  logic [7:0] lcd_db,
	output logic       fall_seen,		// One cycle per latched byte
	output logic       fall_rs,
	output logic [7:0] fall_db,
	output int         timing_errors
);

	timeunit 1ns;
	timeprecision 100ps;

	import lcd_pkg::*;

	logic       e_prev;				// E at the previous falling clock
	logic       have_prev;			// A byte was latched since reset
	logic       prev_rs;
	logic [7:0] prev_db;
	int         cyc;				// Cycle count since reset
	int         high_cnt;			// Cycles E has been high
	int         last_fall;			// Cycle of the previous E fall
	int         need_gap;
	int         err_cnt = 0;

	assign timing_errors = err_cnt;

	// Sampled on the falling clock, where the DUT pins are stable
	always @(negedge CLK) begin
		if (!RST) begin
			e_prev    = 1'b0;
			have_prev = 1'b0;
			cyc       = 0;
			high_cnt  = 0;
			last_fall = 0;
			fall_seen <= 1'b0;
		end else begin
			cyc = cyc + 1;
			fall_seen <= 1'b0;
			if (lcd_e) begin
				high_cnt = high_cnt + 1;
			end
			if (e_prev && !lcd_e) begin
				if (high_cnt < int'(T_PULSE)) begin
					err_cnt = err_cnt + 1;
					$display("[ERROR] %0t: E high for %0d cycles, minimum %0d",
						$time, high_cnt, T_PULSE);
				end
				if (have_prev) begin
					// Clear and home with RS low need the long execution time
					if (!prev_rs && (prev_db == CMD_CLEAR || prev_db == CMD_HOME)) begin
						need_gap = int'(T_EXEC_LONG);
					end else begin
						need_gap = int'(T_EXEC_SHORT);
					end
					if (cyc - last_fall < need_gap) begin
						err_cnt = err_cnt + 1;
						$display("[ERROR] %0t: %0d cycles after DB=%02h, minimum %0d",
							$time, cyc - last_fall, prev_db, need_gap);
					end
				end
				have_prev = 1'b1;
				prev_rs   = lcd_rs;
				prev_db   = lcd_db;
				last_fall = cyc;
				high_cnt  = 0;
				fall_seen <= 1'b1;		// Byte held on DB after the fall
				fall_rs   <= lcd_rs;
				fall_db   <= lcd_db;
			end
			e_prev = lcd_e;
		end
	end

endmodule

//--- test/tb_lcd_ctrl.sv
// ----------------------------------------------------------------------
// Testbench top: clock, reset, random host requests, expected-write queue
// ----------------------------------------------------------------------
module tb_lcd_ctrl;

	timeunit 1ns;
	timeprecision 100ps;

	import lcd_pkg::*;

	logic       CLK;
	logic       RST;
	logic       cmd_valid;
	lcd_op_e    cmd_op;
	logic [7:0] cmd_data;
	logic       rdy;
	logic       lcd_rs;
	logic       lcd_rw;
	logic       lcd_e;
	logic [7:0] lcd_db;
	logic       fall_seen;
	logic       fall_rs;
	logic [7:0] fall_db;
	int         timing_errors;

	logic [8:0] exp_q[$];			// Expected {RS, byte} in bus order
	logic [8:0] got_q[$];			// Latched bytes seen by the monitor
	int         errors = 0;
	int         rw_errors = 0;
	int         passed = 0;
	int         failed = 0;
	logic       timed_out = 1'b0;		// Set once a wait for rdy gave up

	lcd_ctrl_top lcd_ctrl_top_inst (
		.CLK(CLK), .RST(RST), .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_data(cmd_data),
		.rdy(rdy), .lcd_rs(lcd_rs), .lcd_rw(lcd_rw), .lcd_e(lcd_e), .lcd_db(lcd_db)
	);

	lcd_bus_monitor bus_monitor_inst (
		.CLK(CLK), .RST(RST), .lcd_e(lcd_e), .lcd_rs(lcd_rs), .lcd_db(lcd_db),
		.fall_seen(fall_seen), .fall_rs(fall_rs), .fall_db(fall_db),
		.timing_errors(timing_errors)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;			// 10 MHz
	end

	always @(posedge CLK) begin
		if (fall_seen) begin
			got_q.push_back({fall_rs, fall_db});
		end
	end

	always @(negedge CLK) begin
		if (RST && lcd_rw) begin
			rw_errors++;
			$display("[ERROR] %0t: lcd_rw high, expected 0", $time);
		end
	end

	function automatic int total_errors();
		return errors + rw_errors + timing_errors;
	endfunction

	function automatic lcd_op_e rand_op();
		return (($urandom % 2) != 0) ? op_char : op_instr;
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'($urandom);
	endfunction

	task automatic push_init();
		for (int i = 0; i < INIT_LEN; i++) begin
			exp_q.push_back({1'b0, INIT_LIST[i]});	// Init bytes are instructions
		end
	endtask

	// Later waits return at once after the first timeout
	task automatic wait_rdy(input int max_cycles, input string what);
		int n;
		n = 0;
		while (!rdy && !timed_out && n < max_cycles) begin
			@(negedge CLK);
			n++;
		end
		if (!rdy && !timed_out) begin
			timed_out = 1'b1;
			errors++;
			$display("Timeout: rdy did not rise within %0d cycles (%s)", max_cycles, what);
		end
	endtask

	// Called on a falling edge, strobe lasts one cycle
	task automatic send_cmd(input lcd_op_e op, input logic [7:0] data);
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_data  = data;
		if (rdy && (op == op_char || op == op_instr)) begin
			exp_q.push_back({op == op_char, data});	// Accepted only while rdy is high
		end else if (rdy && op == op_reinit) begin
			push_init();
		end
		@(negedge CLK);
		cmd_valid = 1'b0;
		cmd_op    = op_none;
	endtask

	task automatic compare_writes();
		logic [8:0] exp_w;
		logic [8:0] got_w;
		while (exp_q.size() > 0) begin
			exp_w = exp_q.pop_front();
			if (got_q.size() == 0) begin
				errors++;
				$display("Missing bus write: RS=%0b DB=%02h was never latched",
					exp_w[8], exp_w[7:0]);
			end else begin
				got_w = got_q.pop_front();
				if (got_w != exp_w) begin
					errors++;
					$display("[ERROR] %0t: latched RS=%0b DB=%02h, expected RS=%0b DB=%02h",
						$time, got_w[8], got_w[7:0], exp_w[8], exp_w[7:0]);
				end
			end
		end
		while (got_q.size() > 0) begin
			got_w = got_q.pop_front();
			errors++;
			$display("Unexpected bus write: RS=%0b DB=%02h", got_w[8], got_w[7:0]);
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		if (total_errors() == err_before) begin
			passed++;
			$display("PASS  %s", name);
		end else begin
			failed++;
			$display("FAIL  %s (%0d errors)", name, total_errors() - err_before);
		end
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		int base;
		RST       = 1'b0;
		cmd_valid = 1'b0;
		cmd_op    = op_none;
		cmd_data  = '0;
		void'($urandom(32'hf124));
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b1;

		base = total_errors();			// Init list after reset
		if (rdy || lcd_e || lcd_rs || lcd_db != 8'h00) begin
			errors++;
			$display("[ERROR] %0t: rdy=%0b E=%0b RS=%0b DB=%02h after reset, expected all 0",
				$time, rdy, lcd_e, lcd_rs, lcd_db);
		end
		push_init();
		wait_rdy(600000, "power-on init");
		if (got_q.size() != INIT_LEN) begin
			errors++;
			$display("[ERROR] %0t: rdy rose after %0d bytes, expected %0d",
				$time, got_q.size(), INIT_LEN);
		end
		compare_writes();
		end_test("init list after reset", base);

		base = total_errors();			// Random characters and instructions
		for (int i = 0; i < 24; i++) begin
			wait_rdy(20000, "random requests");
			send_cmd(rand_op(), rand_byte());
		end
		wait_rdy(20000, "random requests");
		compare_writes();
		end_test("random char and instr writes", base);

		base = total_errors();			// Strobes while busy and op_none
		for (int i = 0; i < 8; i++) begin
			wait_rdy(20000, "dropped strobes");
			send_cmd(op_none, rand_byte());		// rdy high but nothing to do
			send_cmd(rand_op(), rand_byte());
			for (int k = 0; k < 4; k++) begin
				repeat (($urandom % 50) + 1) @(negedge CLK);
				send_cmd(lcd_op_e'(2'($urandom)), rand_byte());	// Busy, dropped
			end
		end
		wait_rdy(20000, "dropped strobes");
		compare_writes();
		end_test("strobes dropped while busy", base);

		base = total_errors();			// Long and short execution gaps
		wait_rdy(20000, "timing");
		send_cmd(op_instr, CMD_CLEAR);
		wait_rdy(20000, "timing");
		send_cmd(op_char, rand_byte());
		wait_rdy(20000, "timing");
		send_cmd(op_instr, CMD_HOME);
		wait_rdy(20000, "timing");
		send_cmd(op_instr, rand_byte());
		wait_rdy(20000, "timing");
		compare_writes();
		end_test("E pulse width and execution gaps", base);

		base = total_errors();			// Full init again on request
		wait_rdy(20000, "reinit");
		send_cmd(op_reinit, 8'h00);
		if (rdy) begin
			errors++;
			$display("[ERROR] %0t: rdy still high after op_reinit, expected 0", $time);
		end
		wait_rdy(600000, "reinit");
		if (got_q.size() != INIT_LEN) begin
			errors++;
			$display("[ERROR] %0t: rdy rose after %0d bytes, expected %0d",
				$time, got_q.size(), INIT_LEN);
		end
		compare_writes();
		end_test("reinit request", base);

		$display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, total_errors());
		if (failed == 0 && total_errors() == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verilog/lcd_bus_cycle.sv
// ----------------------------------------------------------------------
// One LCD write cycle: RS/DB setup, E pulse, execution wait
// ----------------------------------------------------------------------
module lcd_bus_cycle (
	input  logic       CLK,
	input  logic       RST,
	input  logic       wr_start,		// One-cycle request from sequencer
	input  logic       wr_rs,			// Register select for this write
	input  logic [7:0] wr_db,			// Byte for this write
	output logic       wr_done,			// Execution wait over
	output logic       lcd_rs,
	output logic [7:0] lcd_db,
	output logic       lcd_e
);

	import lcd_pkg::*;

	bus_phase_e         phase;			// Current stage of the write
	logic               tmr_load;
	logic [DELAY_W-1:0] tmr_count;
	logic               tmr_exp;
	logic               start_go;			// Accepted start
	logic               long_exec;			// Clear or home instruction

	assign start_go = (phase == ph_idle) && wr_start;

	// Decided from the latched bus, valid from the setup stage on
	assign long_exec = !lcd_rs && ((lcd_db == CMD_CLEAR) || (lcd_db == CMD_HOME));

	// ----------------------------------------------------------------------
	// Timer loads, one per stage change
	// ----------------------------------------------------------------------
	always_comb begin
		tmr_load  = 1'b0;
		tmr_count = DELAY_W'(T_SETUP);			// Default is the setup wait
		case (phase)
			ph_idle: begin
				tmr_load = start_go;		// Setup time starts with the latch
			end
			ph_setup: begin
				tmr_load  = tmr_exp;		// E rises, time the pulse
				tmr_count = DELAY_W'(T_PULSE);
			end
			ph_pulse: begin
				tmr_load = tmr_exp;		// E falls, time the execution
				if (long_exec) begin
					tmr_count = DELAY_W'(T_EXEC_LONG);
				end else begin
					tmr_count = DELAY_W'(T_EXEC_SHORT);
				end
			end
			default: begin
				tmr_load = 1'b0;		// No reload during execution
			end
		endcase
	end

	lcd_delay_timer stage_timer_inst (
		.CLK     (CLK),
		.RST     (RST),
		.load    (tmr_load),
		.count   (tmr_count),
		.expired (tmr_exp)
	);

	// ----------------------------------------------------------------------
	// Stage sequence and pin registers
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RST) begin
			phase  <= ph_idle;
			lcd_e  <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_db <= '0;
		end else begin
			case (phase)
				ph_idle: begin
					if (start_go) begin
						lcd_rs <= wr_rs;	// Bus set up one cycle after start
						lcd_db <= wr_db;
						phase  <= ph_setup;
					end
				end
				ph_setup: begin
					if (tmr_exp) begin
						lcd_e <= 1'b1;
						phase <= ph_pulse;
					end
				end
				ph_pulse: begin
					if (tmr_exp) begin
						lcd_e <= 1'b0;		// Falling edge latches the byte
						phase <= ph_exec;
					end
				end
				ph_exec: begin
					if (tmr_exp) begin
						phase <= ph_idle;	// DB keeps the last byte
					end
				end
				default: begin
					phase <= ph_idle;
				end
			endcase
		end
	end

	assign wr_done = (phase == ph_exec) && tmr_exp;	// Same cycle the wait ends

endmodule

//--- verilog/lcd_ctrl_top.sv
// ----------------------------------------------------------------------
// LCD controller top, sequencer driving one bus cycle engine
// ----------------------------------------------------------------------
module lcd_ctrl_top (
	input  logic             CLK,
	input  logic             RST,
	input  logic             cmd_valid,		// Dropped while rdy is low
	input  lcd_pkg::lcd_op_e cmd_op,
	input  logic [7:0]       cmd_data,
	output logic             rdy,
	output logic             lcd_rs,
	output logic             lcd_rw,
	output logic             lcd_e,
	output logic [7:0]       lcd_db
);

	// ----------------------------------------------------------------------
	// Sequencer to bus cycle handshake
	// ----------------------------------------------------------------------
	logic       wr_start;
	logic       wr_rs;
	logic [7:0] wr_db;
	logic       wr_done;

	lcd_sequencer sequencer_inst (
		.CLK       (CLK),
		.RST       (RST),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_data  (cmd_data),
		.rdy       (rdy),
		.wr_start  (wr_start),
		.wr_rs     (wr_rs),
		.wr_db     (wr_db),
		.wr_done   (wr_done)
	);

	lcd_bus_cycle bus_cycle_inst (
		.CLK      (CLK),
		.RST      (RST),
		.wr_start (wr_start),
		.wr_rs    (wr_rs),
		.wr_db    (wr_db),
		.wr_done  (wr_done),
		.lcd_rs   (lcd_rs),
		.lcd_db   (lcd_db),
		.lcd_e    (lcd_e)
	);

	assign lcd_rw = 1'b0;			// Write only, busy flag never read

endmodule

//--- verilog/lcd_delay_timer.sv
// ----------------------------------------------------------------------
// Loadable delay down-counter with a one-cycle expiry pulse
// ----------------------------------------------------------------------
module lcd_delay_timer (
	input  logic                        CLK,
	input  logic                        RST,
	input  logic                        load,		// Start or restart the delay
	input  logic [lcd_pkg::DELAY_W-1:0] count,		// Cycles from load to expired
	output logic                        expired		// High for one cycle
);

	import lcd_pkg::*;

	logic [DELAY_W-1:0] cnt;				// Zero when no delay is running

	always_ff @(posedge CLK) begin
		if (!RST) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= count;				// New load wins over a running delay
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;			// Stops at zero
		end
	end

	// Count of one is the last cycle of the delay, so the pulse comes
	// exactly count cycles after the load cycle
	assign expired = (cnt == DELAY_W'(1));

endmodule

//--- verilog/lcd_pkg.sv
// ----------------------------------------------------------------------
// Shared definitions for the HD44780 write-only controller
// Cycle counts at 10 MHz, instruction bytes, init list and enums
// ----------------------------------------------------------------------
package lcd_pkg;

	// ----------------------------------------------------------------------
	// Timing in clock cycles (100 ns each)
	// ----------------------------------------------------------------------
	localparam logic [31:0] T_POWER_ON   = 32'd500_000;	// 50 ms after power up
	localparam logic [31:0] T_INIT_GAP   = 32'd41_000;	// 4.1 ms after first function set
	localparam logic [31:0] T_SETUP      = 32'd1;		// RS and DB settle before E
	localparam logic [31:0] T_PULSE      = 32'd3;		// E high, at least 250 ns
	localparam logic [31:0] T_EXEC_SHORT = 32'd420;		// 42 us for most instructions
	localparam logic [31:0] T_EXEC_LONG  = 32'd16_400;	// 1.64 ms for clear and home

	localparam int DELAY_W = 20;				// Holds the power-on count

	// ----------------------------------------------------------------------
	// Instruction bytes
	// ----------------------------------------------------------------------
	localparam logic [7:0] CMD_FUNC_SET = 8'b0011_1100;	// 8-bit bus, 2 lines, 5x11 font
	localparam logic [7:0] CMD_DISP_OFF = 8'b0000_1000;	// Display, cursor, blink off
	localparam logic [7:0] CMD_CLEAR    = 8'b0000_0001;	// Clear DDRAM, long exec
	localparam logic [7:0] CMD_HOME     = 8'b0000_0010;	// Cursor home, long exec
	localparam logic [7:0] CMD_ENTRY_N  = 8'b0000_0110;	// Increment, no shift
	localparam logic [7:0] CMD_DISP_ON  = 8'b0000_1100;	// Display on, cursor off

	// Init list, sent in this order with RS low
	localparam int INIT_LEN   = 7;
	localparam int INIT_IDX_W = $clog2(INIT_LEN);
	localparam logic [INIT_IDX_W-1:0] INIT_LAST = INIT_IDX_W'(INIT_LEN - 1);	// Index of last byte

	localparam logic [7:0] INIT_LIST [INIT_LEN] = '{
		CMD_FUNC_SET,	// Followed by the extra init gap
		CMD_FUNC_SET,
		CMD_FUNC_SET,
		CMD_DISP_OFF,
		CMD_CLEAR,
		CMD_ENTRY_N,
		CMD_DISP_ON
	};

	// ----------------------------------------------------------------------
	// Enums
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		op_none,		// Strobe ignored
		op_char,		// Write with RS high
		op_instr,		// Write with RS low
		op_reinit		// Rerun power-on wait and init list
	} lcd_op_e;

	typedef enum logic [2:0] {
		st_pwr_wait, st_init_wr, st_init_gap, st_idle, st_host_wr
	} seq_state_e;

	typedef enum logic [1:0] {
		ph_idle, ph_setup, ph_pulse, ph_exec
	} bus_phase_e;

endpackage

//--- verilog/lcd_sequencer.sv
// ----------------------------------------------------------------------
// Power-on wait, init list walk and host request handling
// ----------------------------------------------------------------------
module lcd_sequencer (
	input  logic             CLK,
	input  logic             RST,
	input  logic             cmd_valid,		// One-cycle host strobe
	input  lcd_pkg::lcd_op_e cmd_op,
	input  logic [7:0]       cmd_data,
	output logic             rdy,			// Idle, host may strobe
	output logic             wr_start,		// One-cycle write request
	output logic             wr_rs,
	output logic [7:0]       wr_db,
	input  logic             wr_done		// Write and its wait finished
);

	import lcd_pkg::*;

	seq_state_e            state;
	logic [INIT_IDX_W-1:0] idx;			// Position in INIT_LIST
	logic                  tmr_load;		// Registered load pulse
	logic [DELAY_W-1:0]    tmr_count;
	logic                  tmr_exp;

	// Load is one cycle behind the state change, so the state already
	// tells which delay is wanted
	assign tmr_count = (state == st_init_gap) ? DELAY_W'(T_INIT_GAP) : DELAY_W'(T_POWER_ON);

	lcd_delay_timer wait_timer_inst (
		.CLK     (CLK),
		.RST     (RST),
		.load    (tmr_load),
		.count   (tmr_count),
		.expired (tmr_exp)
	);

	// ----------------------------------------------------------------------
	// Main FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RST) begin
			state    <= st_pwr_wait;
			idx      <= '0;
			rdy      <= 1'b0;
			wr_start <= 1'b0;
			wr_rs    <= 1'b0;
			wr_db    <= '0;
			tmr_load <= 1'b1;			// Power-on wait starts right after reset
		end else begin
			wr_start <= 1'b0;			// Pulses by default
			tmr_load <= 1'b0;
			case (state)
				st_pwr_wait: begin
					if (tmr_exp) begin
						wr_start <= 1'b1;	// First function set
						wr_rs    <= 1'b0;
						wr_db    <= INIT_LIST[idx];
						state    <= st_init_wr;
					end
				end
				st_init_wr: begin
					if (wr_done) begin
						if (idx == INIT_LAST) begin
							rdy   <= 1'b1;	// Display on done
							state <= st_idle;
						end else if (idx == '0) begin
							idx      <= idx + 1'b1;
							tmr_load <= 1'b1;	// Extra gap after first byte
							state    <= st_init_gap;
						end else begin
							idx      <= idx + 1'b1;
							wr_start <= 1'b1;	// Next byte back to back
							wr_db    <= INIT_LIST[idx + 1'b1];
						end
					end
				end
				st_init_gap: begin
					if (tmr_exp) begin
						wr_start <= 1'b1;	// Second function set
						wr_db    <= INIT_LIST[idx];
						state    <= st_init_wr;
					end
				end
				st_idle: begin
					if (cmd_valid && rdy) begin
						case (cmd_op)
							op_char, op_instr: begin
								wr_start <= 1'b1;
								wr_rs    <= (cmd_op == op_char);	// RS high for data
								wr_db    <= cmd_data;
								rdy      <= 1'b0;
								state    <= st_host_wr;
							end
							op_reinit: begin
								rdy      <= 1'b0;
								idx      <= '0;
								tmr_load <= 1'b1;	// Full power-on wait again
								state    <= st_pwr_wait;
							end
							default: begin
								rdy <= 1'b1;	// op_none, nothing to do
							end
						endcase
					end
				end
				st_host_wr: begin
					if (wr_done) begin
						rdy   <= 1'b1;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_pwr_wait;
				end
			endcase
		end
	end

endmodule
